// ==== list.f ====
source/mips_isa_pkg.sv
source/ex_pkg.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_result.sv
source/ex_stage.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - source/mips_isa_pkg.sv
  - source/ex_pkg.sv
  - source/ex_decode.sv
  - source/ex_alu.sv
  - source/ex_mult.sv
  - source/ex_result.sv
  - source/ex_stage.sv
  - target: test
    files:
      - tb/ex_stage_checker.sv
      - tb/ex_stage_tb.sv

// ==== tb/ex_stage_tb.sv ====
// ex_stage_tb: clock, reset, lfsr stimulus, reference model, result checks, watchdog, verdict
`default_nettype none

module ex_stage_tb;

    import mips_isa_pkg::*;
    import ex_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int n_random     = 200;
    localparam int n_mul        = 24;
    // reset reads, random mix, arith edges, multiply rounds, hi/lo moves, traps
    localparam int total_insts  = 2 + n_random + 30 + 3 * n_mul + 6 + 18;

    localparam funct_e r_kinds [16] = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
        fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    localparam opcode_e i_kinds [8] = '{opc_addi, opc_addiu, opc_slti, opc_sltiu,
        opc_andi, opc_ori, opc_xori, opc_lui};
    localparam funct_e arith_kinds [6] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu};
    localparam funct_e trap_kinds [6] = '{fn_tge, fn_tgeu, fn_tlt, fn_tltu, fn_teq, fn_tne};
    localparam ex_pkg::word_t edge_a [4] = '{32'h7fffffff, 32'h80000000, 32'h80000000,
        32'h40000000};
    localparam ex_pkg::word_t edge_b [4] = '{32'h00000001, 32'h00000001, 32'h7fffffff,
        32'h40000000};

    logic        clk = 1'b0;
    logic        reset_i;
    issue_t      issue_i;
    wb_t         result_o;
    logic [15:0] lfsr = 16'd47828;
    hilo_t       model_hilo = '0;
    wb_t         expected_q [$];
    string       name_q [$];

    ex_stage UUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .result_o (result_o)
    );

    bind ex_stage ex_stage_checker u_checker (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .result_i (result_o)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return state[0] ? (state >> 1) ^ 16'hB400 : state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic ex_pkg::word_t rand_word();
        return rand_bits(32);
    endfunction

    function automatic inst_u r_inst(opcode_e op, logic [5:0] funct);
        inst_u inst;
        inst.r.op    = op;
        inst.r.rs    = 5'(rand_bits(5));
        inst.r.rt    = 5'(rand_bits(5));
        inst.r.rd    = 5'(rand_bits(5));
        inst.r.sa    = 5'(rand_bits(5));
        inst.r.funct = funct;
        return inst;
    endfunction

    function automatic inst_u i_inst(opcode_e op, logic [15:0] imm);
        inst_u inst;
        inst.i.op  = op;
        inst.i.rs  = 5'(rand_bits(5));
        inst.i.rt  = 5'(rand_bits(5));
        inst.i.imm = imm;
        return inst;
    endfunction

    // reference model, hi/lo updated in program order
    function automatic wb_t expect_result(inst_u inst, ex_pkg::word_t rs, ex_pkg::word_t rt);
        wb_t           res;
        ex_pkg::word_t b;
        dword_t        prod;
        logic [32:0]   wide;
        logic          do_sum;
        logic          subtract;
        logic          trapping;
        logic          lead_bit;
        res       = '0;
        res.valid = 1'b1;
        res.wreg  = 1'b1;
        res.wd    = (inst.r.op inside {opc_special, opc_special2}) ? inst.r.rd : inst.i.rt;
        do_sum    = 1'b0;
        subtract  = 1'b0;
        trapping  = 1'b0;
        // immediate takes the place of rt
        case (inst.i.op)
            opc_special, opc_special2:   b = rt;
            opc_andi, opc_ori, opc_xori: b = {16'h0000, inst.i.imm};
            default:                     b = {{16{inst.i.imm[15]}}, inst.i.imm};
        endcase
        case (inst.r.op)
            opc_special: begin
                case (inst.r.funct)
                    fn_sll:  res.wdata = rt << inst.r.sa;
                    fn_srl:  res.wdata = rt >> inst.r.sa;
                    fn_sra:  res.wdata = $signed(rt) >>> inst.r.sa;
                    fn_sllv: res.wdata = rt << rs[4:0];
                    fn_srlv: res.wdata = rt >> rs[4:0];
                    fn_srav: res.wdata = $signed(rt) >>> rs[4:0];
                    fn_mfhi: res.wdata = model_hilo.hi;
                    fn_mflo: res.wdata = model_hilo.lo;
                    fn_mthi: model_hilo.hi = rs;
                    fn_mtlo: model_hilo.lo = rs;
                    fn_mult: begin
                        prod       = $signed(rs) * $signed(rt);
                        model_hilo = prod;
                    end
                    fn_multu: begin
                        prod       = rs * rt;
                        model_hilo = prod;
                    end
                    fn_add, fn_addu, fn_sub, fn_subu: begin
                        do_sum   = 1'b1;
                        subtract = inst.r.funct inside {fn_sub, fn_subu};
                        trapping = inst.r.funct inside {fn_add, fn_sub};
                    end
                    fn_and:  res.wdata = rs & b;
                    fn_or:   res.wdata = rs | b;
                    fn_xor:  res.wdata = rs ^ b;
                    fn_nor:  res.wdata = ~(rs | b);
                    fn_slt:  res.wdata = {31'b0, $signed(rs) < $signed(b)};
                    fn_sltu: res.wdata = {31'b0, rs < b};
                    fn_tge:  res.trap = !($signed(rs) < $signed(rt));
                    fn_tgeu: res.trap = !(rs < rt);
                    fn_tlt:  res.trap = $signed(rs) < $signed(rt);
                    fn_tltu: res.trap = rs < rt;
                    fn_teq:  res.trap = (rs == rt);
                    fn_tne:  res.trap = (rs != rt);
                    default: res.wreg = 1'b0;
                endcase
            end
            opc_special2: begin
                if (inst.r.funct == fn2_mul) begin
                    prod      = $signed(rs) * $signed(rt);
                    res.wdata = prod[31:0];
                end else begin
                    lead_bit = (inst.r.funct == fn2_clo);
                    for (int k = 31; k >= 0 && rs[k] == lead_bit; k--) begin
                        res.wdata = res.wdata + 1;
                    end
                end
            end
            opc_addi:  {do_sum, trapping} = 2'b11;
            opc_addiu: do_sum = 1'b1;
            opc_slti:  res.wdata = {31'b0, $signed(rs) < $signed(b)};
            opc_sltiu: res.wdata = {31'b0, rs < b};
            opc_andi:  res.wdata = rs & b;
            opc_ori:   res.wdata = rs | b;
            opc_xori:  res.wdata = rs ^ b;
            default:   res.wdata = {inst.i.imm, 16'h0000};
        endcase
        if (inst.r.op == opc_special && inst.r.funct inside {fn_mthi, fn_mtlo, fn_mult,
                fn_multu, fn_tge, fn_tgeu, fn_tlt, fn_tltu, fn_teq, fn_tne}) begin
            res.wreg = 1'b0;
        end
        if (do_sum) begin
            // extra bit keeps the true signed result
            wide         = subtract ? {rs[31], rs} - {b[31], b} : {rs[31], rs} + {b[31], b};
            res.wdata    = wide[31:0];
            res.overflow = trapping && (wide[32] != wide[31]);
            res.wreg     = !res.overflow;
        end
        return res;
    endfunction

    task automatic issue(inst_u inst, ex_pkg::word_t rs, ex_pkg::word_t rt, string name);
        @(negedge clk);
        issue_i.valid    = 1'b1;
        issue_i.inst     = inst;
        issue_i.rs_value = rs;
        issue_i.rt_value = rt;
        expected_q.push_back(expect_result(inst, rs, rt));
        name_q.push_back(name);
    endtask

    task automatic idle();
        @(negedge clk);
        issue_i = '0;
    endtask

    always @(negedge clk) begin : compare_result
        wb_t   expected;
        string name;
        if (!reset_i && result_o.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run("a valid result arrived with no instruction in flight");
            end else begin
                expected = expected_q.pop_front();
                name     = name_q.pop_front();
                assert (result_o === expected) else begin
                    $display("CHECK FAILED %s: expected %h actual %h", name, expected, result_o);
                    abort_run("result does not match the reference model");
                end
            end
        end
    end

    always @(negedge clk) begin
        assert (UUT.u_checker.error_seen !== 1'b1)
            else abort_run("a concurrent assertion in the checker failed");
    end

    initial begin : watchdog
        #((reset_cycles + total_insts + 50) * clk_period);
        abort_run("watchdog timeout, the instruction stream did not drain in time");
    end

    initial begin : run_tests
        inst_u         inst;
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        reset_i = 1'b1;
        issue_i = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        repeat (5) idle();

        // hi/lo come out of reset as zero
        issue(r_inst(opc_special, fn_mfhi), '0, '0, "reset_hilo");
        issue(r_inst(opc_special, fn_mflo), '0, '0, "reset_hilo");

        repeat (n_random) begin
            a = rand_word();
            b = rand_word();
            case (rand_bits(2))
                0, 1:    inst = r_inst(opc_special, r_kinds[rand_bits(4)]);
                2:       inst = i_inst(i_kinds[rand_bits(3)], 16'(rand_bits(16)));
                default: inst = r_inst(opc_special2, rand_bits(1) ? fn2_clo : fn2_clz);
            endcase
            issue(inst, a, b, "random_alu");
        end

        for (int p = 0; p < 4; p++) begin
            for (int f = 0; f < 6; f++) begin
                issue(r_inst(opc_special, arith_kinds[f]), edge_a[p], edge_b[p], "arith_edge");
            end
        end
        issue(i_inst(opc_addi, 16'h0001), 32'h7fffffff, '0, "addi_overflow");
        issue(i_inst(opc_addi, 16'hffff), 32'h80000000, '0, "addi_overflow");
        issue(r_inst(opc_special2, fn2_clz), 32'h00000000, '0, "leading_count");
        issue(r_inst(opc_special2, fn2_clz), 32'hffffffff, '0, "leading_count");
        issue(r_inst(opc_special2, fn2_clo), 32'hffffffff, '0, "leading_count");
        issue(r_inst(opc_special2, fn2_clo), 32'h00000000, '0, "leading_count");

        for (int i = 0; i < n_mul; i++) begin
            a = rand_word();
            b = rand_word();
            // negative operands on a regular pattern
            if (i % 2 == 0) a[31] = 1'b1;
            if (i % 4 == 0) b[31] = 1'b1;
            case (i % 3)
                0:       inst = r_inst(opc_special, fn_mult);
                1:       inst = r_inst(opc_special, fn_multu);
                default: inst = r_inst(opc_special2, fn2_mul);
            endcase
            issue(inst, a, b, "multiply");
            issue(r_inst(opc_special, fn_mfhi), a, b, "multiply");
            issue(r_inst(opc_special, fn_mflo), a, b, "multiply");
        end

        a = rand_word();
        b = rand_word();
        issue(r_inst(opc_special, fn_mthi), a, b, "hilo_move");
        issue(r_inst(opc_special, fn_mfhi), a, b, "hilo_move");
        issue(r_inst(opc_special, fn_mflo), a, b, "hilo_move");
        issue(r_inst(opc_special, fn_mtlo), b, a, "hilo_move");
        issue(r_inst(opc_special, fn_mfhi), a, b, "hilo_move");
        issue(r_inst(opc_special, fn_mflo), a, b, "hilo_move");

        for (int f = 0; f < 6; f++) begin
            a = rand_word() | 32'h80000000;
            b = rand_word() & 32'h7fffffff;
            issue(r_inst(opc_special, trap_kinds[f]), a, a, "trap");
            issue(r_inst(opc_special, trap_kinds[f]), a, b, "trap");
            issue(r_inst(opc_special, trap_kinds[f]), b, a, "trap");
        end

        idle();
        while (expected_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        if (UUT.u_checker.error_seen === 1'b1) begin
            abort_run("a concurrent assertion in the checker failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/ex_stage_checker.sv ====
// concurrent assertions on reset values, result latency and write enable
`default_nettype none

module ex_stage_checker (
    input wire                 clk,
    input wire                 reset_i,
    input wire ex_pkg::issue_t issue_i,
    input wire ex_pkg::wb_t    result_i
);

    // raised by any failing assertion below
    logic error_seen = 1'b0;

    // the reset edge clears the output flags
    reset_clears: assert property (@(posedge clk)
        reset_i |=> !result_i.valid && !result_i.wreg && !result_i.trap && !result_i.overflow)
        else begin
            $error("output flags not cleared by reset");
            error_seen = 1'b1;
        end

    // one result per issued instruction two edges later
    result_latency: assert property (@(posedge clk) disable iff (reset_i)
        result_i.valid == $past(issue_i.valid, 2))
        else begin
            $error("result valid does not follow issue valid by two cycles");
            error_seen = 1'b1;
        end

    // no flags without a result
    idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
        !result_i.valid |-> !result_i.wreg && !result_i.trap && !result_i.overflow)
        else begin
            $error("write, trap or overflow flag raised without a valid result");
            error_seen = 1'b1;
        end

    trap_no_write: assert property (@(posedge clk) disable iff (reset_i)
        result_i.trap |-> !result_i.wreg)
        else begin
            $error("trap result asserts the register write");
            error_seen = 1'b1;
        end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
// ex_stage: execute stage top, decode register feeding alu, multiplier and result register
`default_nettype none

module ex_stage (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire ex_pkg::issue_t issue_i,
    output ex_pkg::wb_t         result_o
);

    import ex_pkg::*;

    dec_t   dec;
    word_t  alu_word;
    logic   overflow;
    logic   trap;
    dword_t product;

    ex_decode u_decode (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue_i),
        .dec_o   (dec)
    );

    ex_alu u_alu (
        .dec_i      (dec),
        .alu_word_o (alu_word),
        .overflow_o (overflow),
        .trap_o     (trap)
    );

    ex_mult u_mult (
        .dec_i     (dec),
        .product_o (product)
    );

    ex_result u_result (
        .clk        (clk),
        .reset_i    (reset_i),
        .dec_i      (dec),
        .alu_word_i (alu_word),
        .overflow_i (overflow),
        .trap_i     (trap),
        .product_i  (product),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire

// ==== source/ex_result.sv ====
// ex_result: hi/lo register, write data select, overflow write suppression, output register
`default_nettype none

module ex_result (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire ex_pkg::dec_t   dec_i,
    input  wire ex_pkg::word_t  alu_word_i,
    input  wire                 overflow_i,
    input  wire                 trap_i,
    input  wire ex_pkg::dword_t product_i,
    output ex_pkg::wb_t         result_o
);

    import ex_pkg::*;

    hilo_t hilo;
    wb_t   wb_d;

    always_comb begin
        wb_d.valid    = dec_i.valid;
        wb_d.wd       = dec_i.wd;
        // overflowing add/sub must not reach the register file
        wb_d.wreg     = dec_i.wreg && !overflow_i;
        wb_d.trap     = trap_i;
        wb_d.overflow = overflow_i;
        case (dec_i.res_sel)
            res_logic, res_shift, res_arith: wb_d.wdata = alu_word_i;
            res_mul: wb_d.wdata = product_i[word_msb:0];
            res_hi:  wb_d.wdata = hilo.hi;
            res_lo:  wb_d.wdata = hilo.lo;
            default: wb_d.wdata = '0;
        endcase
    end

    // written at the end of execute, so the next instruction sees it directly
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo <= '0;
        end else begin
            case (dec_i.op)
                alu_mult, alu_multu: hilo    <= hilo_t'(product_i);
                alu_mthi:            hilo.hi <= dec_i.src_a;
                alu_mtlo:            hilo.lo <= dec_i.src_a;
                default:             hilo    <= hilo;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o.valid    <= 1'b0;
            result_o.wreg     <= 1'b0;
            result_o.trap     <= 1'b0;
            result_o.overflow <= 1'b0;
        end else begin
            result_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_mult.sv ====
// ex_mult: 32x32 multiply, signed through magnitudes and sign correction
`default_nettype none

module ex_mult (
    input  wire ex_pkg::dec_t dec_i,
    output ex_pkg::dword_t    product_o
);

    import ex_pkg::*;

    logic   signed_op;
    logic   neg_result;
    word_t  a_mag;
    word_t  b_mag;
    dword_t mag_product;

    assign signed_op = dec_i.op inside {alu_mult, alu_mul};

    // multu keeps the raw operands
    assign a_mag = (signed_op && dec_i.src_a[word_msb]) ? ~dec_i.src_a + 1'b1 : dec_i.src_a;
    assign b_mag = (signed_op && dec_i.src_b[word_msb]) ? ~dec_i.src_b + 1'b1 : dec_i.src_b;

    assign mag_product = dword_t'(a_mag) * dword_t'(b_mag);

    assign neg_result = signed_op && (dec_i.src_a[word_msb] ^ dec_i.src_b[word_msb]);
    assign product_o  = neg_result ? ~mag_product + 1'b1 : mag_product;

endmodule

`default_nettype wire

// ==== source/ex_alu.sv ====
// ex_alu: logic, shift, add/subtract, compare, leading count, overflow and trap condition
`default_nettype none

module ex_alu (
    input  wire ex_pkg::dec_t dec_i,
    output ex_pkg::word_t     alu_word_o,
    output logic              overflow_o,
    output logic              trap_o
);

    import ex_pkg::*;

    word_t                     a;
    word_t                     b;
    word_t                     b_mux;
    word_t                     sum;
    word_t                     lead_src;
    logic                      sub_op;
    logic                      signed_cmp;
    logic                      sum_ovf;
    logic                      lt;
    logic                      eq;
    logic [shamt_width-1:0]    shamt;
    logic [lead_cnt_width-1:0] lead_cnt;

    assign a     = dec_i.src_a;
    assign b     = dec_i.src_b;
    assign shamt = a[shamt_width-1:0];

    // signed compares go through the subtractor
    assign sub_op     = dec_i.op inside {alu_subu, alu_sub_trap, alu_slt, alu_tlt, alu_tge};
    assign signed_cmp = dec_i.op inside {alu_slt, alu_tlt, alu_tge};

    assign b_mux = sub_op ? ~b + 1'b1 : b;
    assign sum   = a + b_mux;

    // operands of equal effective sign, result sign flipped
    assign sum_ovf = (a[word_msb] == (b[word_msb] ^ sub_op)) && (sum[word_msb] != a[word_msb]);

    // negative minus positive, or same signs and negative difference
    assign lt = signed_cmp ?
        ((a[word_msb] && !b[word_msb]) || ((a[word_msb] == b[word_msb]) && sum[word_msb])) :
        (a < b);
    assign eq = (a == b);

    assign lead_src = (dec_i.op == alu_clo) ? ~a : a;

    // highest set bit wins, 32 when the word is clear
    always_comb begin
        lead_cnt = lead_cnt_width'($bits(word_t));
        for (int k = 0; k < $bits(word_t); k++) begin
            if (lead_src[k]) begin
                lead_cnt = lead_cnt_width'(word_msb - k);
            end
        end
    end

    always_comb begin
        case (dec_i.op)
            alu_and: alu_word_o = a & b;
            alu_or:  alu_word_o = a | b;
            alu_xor: alu_word_o = a ^ b;
            alu_nor: alu_word_o = ~(a | b);
            alu_sll: alu_word_o = b << shamt;
            alu_srl: alu_word_o = b >> shamt;
            alu_sra: alu_word_o = $signed(b) >>> shamt;
            alu_addu, alu_add_trap, alu_subu, alu_sub_trap: alu_word_o = sum;
            alu_slt, alu_sltu: alu_word_o = word_t'(lt);
            alu_clz, alu_clo:  alu_word_o = word_t'(lead_cnt);
            default: alu_word_o = '0;
        endcase
    end

    assign overflow_o = (dec_i.op inside {alu_add_trap, alu_sub_trap}) && sum_ovf;

    always_comb begin
        case (dec_i.op)
            alu_teq:           trap_o = eq;
            alu_tne:           trap_o = !eq;
            alu_tge, alu_tgeu: trap_o = !lt;
            alu_tlt, alu_tltu: trap_o = lt;
            default:           trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ex_decode.sv ====
// ex_decode: maps the raw instruction to operation, operands and destination, registered
`default_nettype none

module ex_decode (
    input  wire            clk,
    input  wire            reset_i,
    input  wire ex_pkg::issue_t issue_i,
    output ex_pkg::dec_t   dec_o
);

    import mips_isa_pkg::*;
    import ex_pkg::*;

    r_type_t             r_view;
    i_type_t             i_view;
    mips_isa_pkg::word_t imm_sext;
    mips_isa_pkg::word_t imm_zext;
    mips_isa_pkg::word_t sa_word;
    dec_t                dec_d;

    assign r_view   = issue_i.inst.r;
    assign i_view   = issue_i.inst.i;
    assign imm_sext = {{16{i_view.imm[15]}}, i_view.imm};
    assign imm_zext = {16'h0000, i_view.imm};
    assign sa_word  = word_width'(r_view.sa);

    always_comb begin
        dec_d.valid   = issue_i.valid;
        dec_d.op      = alu_nop;
        dec_d.res_sel = res_none;
        dec_d.src_a   = issue_i.rs_value;
        dec_d.src_b   = issue_i.rt_value;
        dec_d.wd      = r_view.rd;
        dec_d.wreg    = 1'b0;

        // operation and immediate operand
        case (r_view.op)
            opc_special: begin
                case (r_view.funct)
                    fn_sll, fn_sllv: dec_d.op = alu_sll;
                    fn_srl, fn_srlv: dec_d.op = alu_srl;
                    fn_sra, fn_srav: dec_d.op = alu_sra;
                    fn_mfhi:         dec_d.op = alu_mfhi;
                    fn_mflo:         dec_d.op = alu_mflo;
                    fn_mthi:         dec_d.op = alu_mthi;
                    fn_mtlo:         dec_d.op = alu_mtlo;
                    fn_mult:         dec_d.op = alu_mult;
                    fn_multu:        dec_d.op = alu_multu;
                    fn_add:          dec_d.op = alu_add_trap;
                    fn_addu:         dec_d.op = alu_addu;
                    fn_sub:          dec_d.op = alu_sub_trap;
                    fn_subu:         dec_d.op = alu_subu;
                    fn_and:          dec_d.op = alu_and;
                    fn_or:           dec_d.op = alu_or;
                    fn_xor:          dec_d.op = alu_xor;
                    fn_nor:          dec_d.op = alu_nor;
                    fn_slt:          dec_d.op = alu_slt;
                    fn_sltu:         dec_d.op = alu_sltu;
                    fn_tge:          dec_d.op = alu_tge;
                    fn_tgeu:         dec_d.op = alu_tgeu;
                    fn_tlt:          dec_d.op = alu_tlt;
                    fn_tltu:         dec_d.op = alu_tltu;
                    fn_teq:          dec_d.op = alu_teq;
                    fn_tne:          dec_d.op = alu_tne;
                    default:         dec_d.op = alu_nop;
                endcase
                // fixed shifts take the amount from sa
                if (r_view.funct inside {fn_sll, fn_srl, fn_sra}) begin
                    dec_d.src_a = sa_word;
                end
            end
            opc_special2: begin
                case (r_view.funct)
                    fn2_mul: dec_d.op = alu_mul;
                    fn2_clz: dec_d.op = alu_clz;
                    fn2_clo: dec_d.op = alu_clo;
                    default: dec_d.op = alu_nop;
                endcase
            end
            opc_addi: begin
                dec_d.op    = alu_add_trap;
                dec_d.src_b = imm_sext;
            end
            opc_addiu: begin
                dec_d.op    = alu_addu;
                dec_d.src_b = imm_sext;
            end
            opc_slti: begin
                dec_d.op    = alu_slt;
                dec_d.src_b = imm_sext;
            end
            opc_sltiu: begin
                dec_d.op    = alu_sltu;
                dec_d.src_b = imm_sext;
            end
            opc_andi: begin
                dec_d.op    = alu_and;
                dec_d.src_b = imm_zext;
            end
            opc_ori: begin
                dec_d.op    = alu_or;
                dec_d.src_b = imm_zext;
            end
            opc_xori: begin
                dec_d.op    = alu_xor;
                dec_d.src_b = imm_zext;
            end
            opc_lui: begin
                // upper half or-ed with zero
                dec_d.op    = alu_or;
                dec_d.src_a = '0;
                dec_d.src_b = {i_view.imm, 16'h0000};
            end
            default: dec_d.op = alu_nop;
        endcase

        // immediate forms write rt
        if (r_view.op != opc_special && r_view.op != opc_special2) begin
            dec_d.wd = i_view.rt;
        end

        if (!issue_i.valid) begin
            dec_d.op = alu_nop;
        end

        // result source and write enable follow from the operation
        case (dec_d.op)
            alu_and, alu_or, alu_xor, alu_nor: begin
                dec_d.res_sel = res_logic;
                dec_d.wreg    = 1'b1;
            end
            alu_sll, alu_srl, alu_sra: begin
                dec_d.res_sel = res_shift;
                dec_d.wreg    = 1'b1;
            end
            alu_addu, alu_add_trap, alu_subu, alu_sub_trap,
            alu_slt, alu_sltu, alu_clz, alu_clo: begin
                dec_d.res_sel = res_arith;
                dec_d.wreg    = 1'b1;
            end
            alu_mul: begin
                dec_d.res_sel = res_mul;
                dec_d.wreg    = 1'b1;
            end
            alu_mfhi: begin
                dec_d.res_sel = res_hi;
                dec_d.wreg    = 1'b1;
            end
            alu_mflo: begin
                dec_d.res_sel = res_lo;
                dec_d.wreg    = 1'b1;
            end
            default: begin
                dec_d.res_sel = res_none;
                dec_d.wreg    = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_o.valid   <= 1'b0;
            dec_o.op      <= alu_nop;
            dec_o.res_sel <= res_none;
            dec_o.wreg    <= 1'b0;
        end else begin
            dec_o <= dec_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_pkg.sv ====
// execute stage package: word types, operation codes, result select and stage structs
`default_nettype none

package ex_pkg;

    typedef mips_isa_pkg::word_t     word_t;
    typedef mips_isa_pkg::reg_addr_t reg_addr_t;

    localparam int word_msb       = mips_isa_pkg::word_width - 1;
    localparam int dword_width    = 2 * mips_isa_pkg::word_width;
    localparam int shamt_width    = $clog2(mips_isa_pkg::word_width);
    localparam int lead_cnt_width = shamt_width + 1;

    typedef logic [dword_width-1:0] dword_t;

    // one code per instruction class, immediates reuse the register code
    typedef enum logic [4:0] {
        alu_nop,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_addu,
        alu_add_trap,
        alu_subu,
        alu_sub_trap,
        alu_slt,
        alu_sltu,
        alu_clz,
        alu_clo,
        alu_mult,
        alu_multu,
        alu_mul,
        alu_mfhi,
        alu_mflo,
        alu_mthi,
        alu_mtlo,
        alu_teq,
        alu_tne,
        alu_tge,
        alu_tgeu,
        alu_tlt,
        alu_tltu
    } alu_op_e;

    typedef enum logic [2:0] {
        res_none,
        res_logic,
        res_shift,
        res_arith,
        res_mul,
        res_hi,
        res_lo
    } res_sel_e;

    typedef struct packed {
        logic                valid;
        mips_isa_pkg::inst_u inst;
        word_t               rs_value;
        word_t               rt_value;
    } issue_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        res_sel_e  res_sel;
        word_t     src_a;
        word_t     src_b;
        reg_addr_t wd;
        logic      wreg;
    } dec_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        logic      trap;
        logic      overflow;
    } wb_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

`default_nettype wire

// ==== source/mips_isa_pkg.sv ====
// mips isa package: field widths, opcode and function encodings, instruction views
`default_nettype none

package mips_isa_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        opc_special  = 6'b000000,
        opc_addi     = 6'b001000,
        opc_addiu    = 6'b001001,
        opc_slti     = 6'b001010,
        opc_sltiu    = 6'b001011,
        opc_andi     = 6'b001100,
        opc_ori      = 6'b001101,
        opc_xori     = 6'b001110,
        opc_lui      = 6'b001111,
        opc_special2 = 6'b011100
    } opcode_e;

    // function field of the special opcode
    typedef enum logic [5:0] {
        fn_sll   = 6'b000000,
        fn_srl   = 6'b000010,
        fn_sra   = 6'b000011,
        fn_sllv  = 6'b000100,
        fn_srlv  = 6'b000110,
        fn_srav  = 6'b000111,
        fn_mfhi  = 6'b010000,
        fn_mthi  = 6'b010001,
        fn_mflo  = 6'b010010,
        fn_mtlo  = 6'b010011,
        fn_mult  = 6'b011000,
        fn_multu = 6'b011001,
        fn_add   = 6'b100000,
        fn_addu  = 6'b100001,
        fn_sub   = 6'b100010,
        fn_subu  = 6'b100011,
        fn_and   = 6'b100100,
        fn_or    = 6'b100101,
        fn_xor   = 6'b100110,
        fn_nor   = 6'b100111,
        fn_slt   = 6'b101010,
        fn_sltu  = 6'b101011,
        fn_tge   = 6'b110000,
        fn_tgeu  = 6'b110001,
        fn_tlt   = 6'b110010,
        fn_tltu  = 6'b110011,
        fn_teq   = 6'b110100,
        fn_tne   = 6'b110110
    } funct_e;

    // function field of the special2 opcode
    typedef enum logic [5:0] {
        fn2_mul = 6'b000010,
        fn2_clz = 6'b100000,
        fn2_clo = 6'b100001
    } funct2_e;

    typedef struct packed {
        opcode_e    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_type_t;

    // same word, register or immediate layout
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

endpackage

`default_nettype wire
